// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Major opcodes
    localparam opcode_t LUI_OP    = 7'b0110111;
    localparam opcode_t AUIPC_OP  = 7'b0010111;
    localparam opcode_t JAL_OP    = 7'b1101111;
    localparam opcode_t JALR_OP   = 7'b1100111;
    localparam opcode_t BRANCH_OP = 7'b1100011;
    localparam opcode_t LOAD_OP   = 7'b0000011;
    localparam opcode_t STORE_OP  = 7'b0100011;
    localparam opcode_t I_TYPE_OP = 7'b0010011;
    localparam opcode_t R_TYPE_OP = 7'b0110011;
    localparam opcode_t SYSTEM_OP = 7'b1110011;

    // Immediate formats
    typedef logic [2:0] imm_type_t;

    localparam imm_type_t I_TYPE       = 3'b000;
    localparam imm_type_t B_TYPE       = 3'b001;
    localparam imm_type_t S_TYPE       = 3'b010;
    localparam imm_type_t U_TYPE       = 3'b011;
    localparam imm_type_t J_TYPE       = 3'b100;
    // Shift amount, zero extended
    localparam imm_type_t SHAMT_TYPE   = 3'b101;
    // uimm from the rs1 field
    localparam imm_type_t CSR_TYPE     = 3'b110;
    localparam imm_type_t DEFAULT_TYPE = 3'b111;

    // mret, funct12 0x302 under SYSTEM
    localparam word_t MRET_IR = 32'b0011000_00010_00000_000_00000_1110011;

endpackage

// ==== hdl/rv_csr_pkg.sv ====
package rv_csr_pkg;

    // Twelve-bit CSR address space
    typedef logic [11:0] csr_addr_t;

    // Machine trap setup and handling
    localparam csr_addr_t MTVEC_ADDR    = 12'h305;
    localparam csr_addr_t MSCRATCH_ADDR = 12'h340;
    localparam csr_addr_t MEPC_ADDR     = 12'h341;

endpackage

// ==== hdl/imm_extractor.sv ====
`timescale 1ns/100ps

module imm_extractor
    import rv_isa_pkg::*;
(
    input  word_t     ir,
    input  imm_type_t imm_type,
    output word_t     imm
);

    always_comb begin
        case (imm_type)
            I_TYPE: begin
                imm = {{20{ir[31]}}, ir[31:20]};
            end
            // Offsets in multiples of two bytes
            B_TYPE: begin
                imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            S_TYPE: begin
                imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            end
            U_TYPE: begin
                imm = {ir[31:12], 12'b0};
            end
            J_TYPE: begin
                imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            SHAMT_TYPE: begin
                imm = {27'b0, ir[24:20]};
            end
            CSR_TYPE: begin
                imm = {27'b0, ir[19:15]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  word_t     ir,

    // Register file read addresses
    output reg_addr_t rs1,
    output reg_addr_t rs2,

    // To execute
    output reg_addr_t rd,
    output opcode_t   opcode,
    output funct3_t   funct3,
    output funct7_t   funct7,
    output csr_addr_t csr_addr,
    output word_t     imm,
    // Active low write enables
    output logic      wr_reg_n,
    output logic      wr_csr_n,
    output logic      is_mret
);

    imm_type_t imm_type;
    logic      is_csr;
    logic      reg_whitelist;

    // Fixed field positions
    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    assign is_mret = (ir == MRET_IR);

    // mret reads mepc so the forwarded value is used as target
    assign csr_addr = is_mret ? MEPC_ADDR : ir[31:20];

    // funct3 of zero under SYSTEM is ecall, ebreak or mret
    assign is_csr = (opcode == SYSTEM_OP) && (funct3 != 3'b000);

    always_comb begin
        case (opcode)
            LUI_OP,
            AUIPC_OP: begin
                imm_type = U_TYPE;
            end
            JAL_OP: begin
                imm_type = J_TYPE;
            end
            JALR_OP,
            LOAD_OP: begin
                imm_type = I_TYPE;
            end
            BRANCH_OP: begin
                imm_type = B_TYPE;
            end
            STORE_OP: begin
                imm_type = S_TYPE;
            end
            I_TYPE_OP: begin
                // SLLI, SRLI and SRAI take a shift amount
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_type = SHAMT_TYPE;
                end else begin
                    imm_type = I_TYPE;
                end
            end
            SYSTEM_OP: begin
                imm_type = CSR_TYPE;
            end
            default: begin
                imm_type = DEFAULT_TYPE;
            end
        endcase
    end

    imm_extractor imm_extractor_inst (
        .ir       (ir),
        .imm_type (imm_type),
        .imm      (imm)
    );

    // Opcodes allowed to write rd, no data memory so LOAD is left out
    assign reg_whitelist = (opcode == LUI_OP)    || (opcode == AUIPC_OP) ||
                           (opcode == JAL_OP)    || (opcode == JALR_OP)  ||
                           (opcode == I_TYPE_OP) || (opcode == R_TYPE_OP) ||
                           is_csr;

    assign wr_reg_n = !(reg_whitelist && (rd != 5'd0));

    // CSRRS with rs1 of x0 is a plain CSR read
    assign wr_csr_n = !(is_csr && !((funct3 == 3'b010) && (rs1 == 5'd0)));

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    // x1 to x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hdl/csr_file.sv ====
`timescale 1ns/100ps

module csr_file
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  csr_addr_t rd_addr,
    output word_t     rdata,
    input  logic      wr_en,
    input  csr_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t mtvec;
    word_t mscratch;
    word_t mepc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                // Direct mode only, base stays word aligned
                MTVEC_ADDR:    mtvec    <= {wr_data[31:2], 2'b00};
                MSCRATCH_ADDR: mscratch <= wr_data;
                MEPC_ADDR:     mepc     <= {wr_data[31:2], 2'b00};
                default:       ;
            endcase
        end
    end

    always_comb begin
        case (rd_addr)
            MTVEC_ADDR:    rdata = mtvec;
            MSCRATCH_ADDR: rdata = mscratch;
            MEPC_ADDR:     rdata = mepc;
            default:       rdata = '0;
        endcase
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      ir_valid,
    input  word_t     pc,

    // From decode
    input  reg_addr_t rd,
    input  opcode_t   opcode,
    input  funct3_t   funct3,
    input  funct7_t   funct7,
    input  csr_addr_t csr_addr,
    input  word_t     imm,
    input  logic      wr_reg_n,
    input  logic      wr_csr_n,
    input  logic      is_mret,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,

    // Storage read data
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  word_t     csr_rdata,

    // Older results for forwarding
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    input  logic      csr_wb_valid,
    input  csr_addr_t csr_wb_addr,
    input  word_t     csr_wb_data,

    output logic      ex_valid,
    output logic      ex_wr_reg,
    output logic      ex_wr_csr,
    output logic      ex_redirect,
    output reg_addr_t ex_rd,
    output word_t     ex_result,
    output word_t     ex_csr_wdata,
    output word_t     ex_redirect_pc,
    output csr_addr_t ex_csr_addr
);

    word_t op_a;
    word_t op_b_reg;
    word_t op_b;
    word_t csr_old;
    word_t csr_src;
    word_t csr_new;
    word_t alu_out;
    word_t result;
    word_t target;
    logic  taken;
    logic  redirect;

    // Youngest match wins, x0 never carries a write enable
    always_comb begin
        op_a = rs1_data;
        if (ex_valid && ex_wr_reg && (ex_rd == rs1_addr)) begin
            op_a = ex_result;
        end else if (wb_valid && (wb_rd == rs1_addr)) begin
            op_a = wb_data;
        end

        op_b_reg = rs2_data;
        if (ex_valid && ex_wr_reg && (ex_rd == rs2_addr)) begin
            op_b_reg = ex_result;
        end else if (wb_valid && (wb_rd == rs2_addr)) begin
            op_b_reg = wb_data;
        end

        csr_old = csr_rdata;
        if (ex_valid && ex_wr_csr && (ex_csr_addr == csr_addr)) begin
            csr_old = ex_csr_wdata;
        end else if (csr_wb_valid && (csr_wb_addr == csr_addr)) begin
            csr_old = csr_wb_data;
        end
    end

    assign op_b = (opcode == I_TYPE_OP) ? imm : op_b_reg;

    // funct7[5] selects sub and arithmetic right shift
    always_comb begin
        case (funct3)
            3'b000: begin
                if ((opcode == R_TYPE_OP) && funct7[5]) begin
                    alu_out = op_a - op_b;
                end else begin
                    alu_out = op_a + op_b;
                end
            end
            3'b001: alu_out = op_a << op_b[4:0];
            3'b010: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            3'b011: alu_out = {31'b0, op_a < op_b};
            3'b100: alu_out = op_a ^ op_b;
            3'b101: begin
                if (funct7[5]) begin
                    alu_out = $signed(op_a) >>> op_b[4:0];
                end else begin
                    alu_out = op_a >> op_b[4:0];
                end
            end
            3'b110: alu_out = op_a | op_b;
            default: alu_out = op_a & op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = (op_a == op_b_reg);
            3'b001:  taken = (op_a != op_b_reg);
            3'b100:  taken = ($signed(op_a) < $signed(op_b_reg));
            3'b101:  taken = ($signed(op_a) >= $signed(op_b_reg));
            3'b110:  taken = (op_a < op_b_reg);
            3'b111:  taken = (op_a >= op_b_reg);
            default: taken = 1'b0;
        endcase
    end

    // Immediate forms take uimm from decode
    assign csr_src = funct3[2] ? imm : op_a;

    always_comb begin
        case (funct3[1:0])
            2'b01:   csr_new = csr_src;
            2'b10:   csr_new = csr_old | csr_src;
            2'b11:   csr_new = csr_old & ~csr_src;
            default: csr_new = csr_old;
        endcase
    end

    always_comb begin
        result   = alu_out;
        redirect = 1'b0;
        target   = pc + imm;
        case (opcode)
            LUI_OP:   result = imm;
            AUIPC_OP: result = pc + imm;
            JAL_OP: begin
                result   = pc + 32'd4;
                redirect = 1'b1;
            end
            JALR_OP: begin
                result   = pc + 32'd4;
                redirect = 1'b1;
                target   = (op_a + imm) & ~32'd1;
            end
            BRANCH_OP: redirect = taken;
            SYSTEM_OP: begin
                result = csr_old;
                // Return to forwarded mepc
                if (is_mret) begin
                    redirect = 1'b1;
                    target   = csr_old;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid    <= 1'b0;
            ex_wr_reg   <= 1'b0;
            ex_wr_csr   <= 1'b0;
            ex_redirect <= 1'b0;
        end else begin
            ex_valid <= ir_valid;
            if (ir_valid) begin
                ex_wr_reg   <= !wr_reg_n;
                ex_wr_csr   <= !wr_csr_n;
                ex_redirect <= redirect;
            end
        end
    end

    always_ff @(posedge clk) begin
        ex_rd          <= rd;
        ex_result      <= result;
        ex_csr_addr    <= csr_addr;
        ex_csr_wdata   <= csr_new;
        ex_redirect_pc <= target;
    end

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/100ps

module result_stage
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      ex_valid,
    input  logic      ex_wr_reg,
    input  logic      ex_wr_csr,
    input  logic      ex_redirect,
    input  reg_addr_t ex_rd,
    input  word_t     ex_result,
    input  word_t     ex_csr_wdata,
    input  word_t     ex_redirect_pc,
    input  csr_addr_t ex_csr_addr,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      csr_wb_valid,
    output csr_addr_t csr_wb_addr,
    output word_t     csr_wb_data,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    // Enables from execute hold their last value while idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid       <= 1'b0;
            csr_wb_valid   <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            wb_valid       <= ex_valid && ex_wr_reg;
            csr_wb_valid   <= ex_valid && ex_wr_csr;
            redirect_valid <= ex_valid && ex_redirect;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= ex_rd;
        wb_data     <= ex_result;
        csr_wb_addr <= ex_csr_addr;
        csr_wb_data <= ex_csr_wdata;
        redirect_pc <= ex_redirect_pc;
    end

endmodule

// ==== hdl/exec_slice_top.sv ====
`timescale 1ns/100ps

module exec_slice_top
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      ir_valid,
    input  word_t     ir,
    input  word_t     pc,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      csr_wb_valid,
    output csr_addr_t csr_wb_addr,
    output word_t     csr_wb_data,
    output logic      redirect_valid,
    output word_t     redirect_pc
);

    // Decode outputs
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    csr_addr_t csr_addr;
    word_t     imm;
    logic      wr_reg_n;
    logic      wr_csr_n;
    logic      is_mret;

    // Storage read data
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     csr_rdata;

    // Execute to result
    logic      ex_valid;
    logic      ex_wr_reg;
    logic      ex_wr_csr;
    logic      ex_redirect;
    reg_addr_t ex_rd;
    word_t     ex_result;
    word_t     ex_csr_wdata;
    word_t     ex_redirect_pc;
    csr_addr_t ex_csr_addr;

    decode_stage decode_stage_inst (
        .ir, .rs1, .rs2, .rd, .opcode, .funct3, .funct7,
        .csr_addr, .imm, .wr_reg_n, .wr_csr_n, .is_mret
    );

    reg_file reg_file_inst (
        .clk, .arst_n, .rs1, .rs2, .rs1_data, .rs2_data,
        .wr_en   (wb_valid),
        .wr_addr (wb_rd),
        .wr_data (wb_data)
    );

    csr_file csr_file_inst (
        .clk, .arst_n,
        .rd_addr (csr_addr),
        .rdata   (csr_rdata),
        .wr_en   (csr_wb_valid),
        .wr_addr (csr_wb_addr),
        .wr_data (csr_wb_data)
    );

    execute_stage execute_stage_inst (
        .clk, .arst_n, .ir_valid, .pc,
        .rd, .opcode, .funct3, .funct7, .csr_addr, .imm,
        .wr_reg_n, .wr_csr_n, .is_mret,
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data, .rs2_data, .csr_rdata,
        .wb_valid, .wb_rd, .wb_data,
        .csr_wb_valid, .csr_wb_addr, .csr_wb_data,
        .ex_valid, .ex_wr_reg, .ex_wr_csr, .ex_redirect,
        .ex_rd, .ex_result, .ex_csr_wdata, .ex_redirect_pc, .ex_csr_addr
    );

    result_stage result_stage_inst (
        .clk, .arst_n,
        .ex_valid, .ex_wr_reg, .ex_wr_csr, .ex_redirect,
        .ex_rd, .ex_result, .ex_csr_wdata, .ex_redirect_pc, .ex_csr_addr,
        .wb_valid, .wb_rd, .wb_data,
        .csr_wb_valid, .csr_wb_addr, .csr_wb_data,
        .redirect_valid, .redirect_pc
    );

endmodule

// ==== test/exec_slice_sva.sv ====
`timescale 1ns/100ps

module exec_slice_sva
    import rv_isa_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input logic      wb_valid,
    input reg_addr_t wb_rd,
    input logic      csr_wb_valid,
    input logic      redirect_valid,
    input word_t     redirect_pc
);

    // x0 never commits
    assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> (wb_rd != 5'd0))
        else $error("wb_valid with wb_rd of zero");

    assert property (@(posedge clk)
        !arst_n |-> (!wb_valid && !csr_wb_valid && !redirect_valid))
        else $error("output valid set during reset");

    // Targets are word aligned
    assert property (@(posedge clk) disable iff (!arst_n)
        redirect_valid |-> (redirect_pc[1:0] == 2'b00))
        else $error("redirect_pc not word aligned");

endmodule

bind exec_slice_top exec_slice_sva sva_inst (.*);

// ==== test/exec_slice_tb.sv ====
`timescale 1ns/100ps

module exec_slice_tb
    import rv_isa_pkg::*;
    import rv_csr_pkg::*;
;

    logic      clk;
    logic      arst_n;
    logic      ir_valid;
    word_t     ir;
    word_t     pc;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      csr_wb_valid;
    csr_addr_t csr_wb_addr;
    word_t     csr_wb_data;
    logic      redirect_valid;
    word_t     redirect_pc;

    // Instruction table with expected commit
    word_t     tab_ir [64];
    word_t     tab_pc [64];
    logic      tab_wv [64];
    reg_addr_t tab_rd [64];
    word_t     tab_data [64];
    logic      tab_cv [64];
    csr_addr_t tab_caddr [64];
    word_t     tab_cdata [64];
    logic      tab_rv [64];
    word_t     tab_rpc [64];
    logic      tab_chain [64];
    int        count = 0;
    word_t     cur_pc = 32'h100;
    logic      chained = 1'b0;

    int        errors = 0;
    int        checks = 0;
    int        drive_idx = -1;
    int        pending [$];
    logic [31:0] lcg_state = 32'd5;

    exec_slice_top uut (
        .clk, .arst_n, .ir_valid, .ir, .pc,
        .wb_valid, .wb_rd, .wb_data,
        .csr_wb_valid, .csr_wb_addr, .csr_wb_data,
        .redirect_valid, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'b0, lcg_state[30:16]};
    endfunction

    // Instruction word builders
    function automatic word_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
                                         input funct3_t f3, input reg_addr_t rd,
                                         input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t rtype_word(input funct7_t f7, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input funct3_t f3,
                                         input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, R_TYPE_OP};
    endfunction

    function automatic word_t utype_word(input logic [19:0] up, input reg_addr_t rd,
                                         input opcode_t op);
        return {up, rd, op};
    endfunction

    function automatic word_t branch_word(input logic [12:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH_OP};
    endfunction

    function automatic word_t jal_word(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL_OP};
    endfunction

    task automatic add_entry(input word_t w, input logic wv, input reg_addr_t rd,
                             input word_t d, input logic cv, input csr_addr_t ca,
                             input word_t cd, input logic rv, input word_t rp);
        tab_ir[count]    = w;
        tab_pc[count]    = cur_pc;
        tab_wv[count]    = wv;
        tab_rd[count]    = rd;
        tab_data[count]  = d;
        tab_cv[count]    = cv;
        tab_caddr[count] = ca;
        tab_cdata[count] = cd;
        tab_rv[count]    = rv;
        tab_rpc[count]   = rp;
        tab_chain[count] = chained;
        cur_pc = cur_pc + 32'd4;
        count++;
    endtask

    task automatic add_reg(input word_t w, input reg_addr_t rd, input word_t d);
        add_entry(w, 1'b1, rd, d, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic add_branch(input word_t w, input logic rv, input word_t rp);
        add_entry(w, 1'b0, '0, '0, 1'b0, '0, '0, rv, rp);
    endtask

    task automatic build_table();
        // ALU, upper immediates and forwarding chains
        add_reg(itype_word(12'h005, 5'd0, 3'b000, 5'd1, I_TYPE_OP), 5'd1, 32'h5);
        // Dependent entries follow without idle cycles
        chained = 1'b1;
        add_reg(itype_word(12'hFFD, 5'd0, 3'b000, 5'd2, I_TYPE_OP), 5'd2, 32'hFFFF_FFFD);
        add_reg(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 32'h2);
        add_reg(rtype_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 5'd4, 32'hFFFF_FFFD);
        add_reg(itype_word(12'h001, 5'd3, 3'b000, 5'd16, I_TYPE_OP), 5'd16, 32'h3);
        add_reg(rtype_word(7'h00, 5'd3, 5'd16, 3'b000, 5'd17), 5'd17, 32'h5);
        chained = 1'b0;
        add_reg(utype_word(20'h12345, 5'd5, LUI_OP), 5'd5, 32'h1234_5000);
        add_reg(utype_word(20'h00001, 5'd6, AUIPC_OP), 5'd6, cur_pc + 32'h1000);
        add_reg(itype_word(12'h401, 5'd2, 3'b101, 5'd7, I_TYPE_OP), 5'd7, 32'hFFFF_FFFE);
        add_reg(itype_word(12'h01C, 5'd2, 3'b101, 5'd8, I_TYPE_OP), 5'd8, 32'hF);
        add_reg(itype_word(12'h004, 5'd1, 3'b001, 5'd9, I_TYPE_OP), 5'd9, 32'h50);
        add_reg(rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd10), 5'd10, 32'h1);
        add_reg(rtype_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd11), 5'd11, 32'h0);
        add_reg(rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd12), 5'd12, 32'hFFFF_FFF8);
        add_reg(rtype_word(7'h00, 5'd9, 5'd1, 3'b110, 5'd13), 5'd13, 32'h55);
        add_reg(rtype_word(7'h00, 5'd9, 5'd2, 3'b111, 5'd14), 5'd14, 32'h50);
        add_reg(itype_word(12'h0FF, 5'd12, 3'b111, 5'd15, I_TYPE_OP), 5'd15, 32'hF8);
        // Write suppression
        add_branch(itype_word(12'h007, 5'd1, 3'b000, 5'd0, I_TYPE_OP), 1'b0, '0);
        add_branch(itype_word(12'h000, 5'd1, 3'b010, 5'd18, LOAD_OP), 1'b0, '0);
        // Branch conditions with x1 = 5 and x2 = -3
        add_branch(branch_word(13'h0008, 5'd1, 5'd1, 3'b000), 1'b1, cur_pc + 32'd8);
        add_branch(branch_word(13'h0008, 5'd1, 5'd1, 3'b001), 1'b0, '0);
        add_branch(branch_word(13'h1FF0, 5'd1, 5'd2, 3'b100), 1'b1, cur_pc - 32'd16);
        add_branch(branch_word(13'h0010, 5'd1, 5'd2, 3'b101), 1'b0, '0);
        add_branch(branch_word(13'h0020, 5'd2, 5'd1, 3'b110), 1'b1, cur_pc + 32'd32);
        add_branch(branch_word(13'h0020, 5'd2, 5'd1, 3'b111), 1'b0, '0);
        add_branch(branch_word(13'h000C, 5'd1, 5'd2, 3'b111), 1'b1, cur_pc + 32'd12);
        add_branch(branch_word(13'h000C, 5'd1, 5'd2, 3'b110), 1'b0, '0);
        add_branch(branch_word(13'h0004, 5'd2, 5'd1, 3'b100), 1'b0, '0);
        add_branch(branch_word(13'h0004, 5'd2, 5'd1, 3'b101), 1'b1, cur_pc + 32'd4);
        // Jumps link pc+4
        add_entry(jal_word(21'h000100, 5'd20), 1'b1, 5'd20, cur_pc + 32'd4,
                  1'b0, '0, '0, 1'b1, cur_pc + 32'h100);
        add_entry(itype_word(12'h005, 5'd9, 3'b000, 5'd21, JALR_OP), 1'b1, 5'd21,
                  cur_pc + 32'd4, 1'b0, '0, '0, 1'b1, 32'h54);
        // CSR operations on mscratch
        add_entry(itype_word(MSCRATCH_ADDR, 5'd1, 3'b001, 5'd22, SYSTEM_OP), 1'b1, 5'd22,
                  32'h0, 1'b1, MSCRATCH_ADDR, 32'h5, 1'b0, '0);
        chained = 1'b1;
        add_entry(itype_word(MSCRATCH_ADDR, 5'd9, 3'b010, 5'd23, SYSTEM_OP), 1'b1, 5'd23,
                  32'h5, 1'b1, MSCRATCH_ADDR, 32'h55, 1'b0, '0);
        add_entry(itype_word(MSCRATCH_ADDR, 5'd1, 3'b011, 5'd24, SYSTEM_OP), 1'b1, 5'd24,
                  32'h55, 1'b1, MSCRATCH_ADDR, 32'h50, 1'b0, '0);
        add_reg(itype_word(MSCRATCH_ADDR, 5'd0, 3'b010, 5'd25, SYSTEM_OP), 5'd25, 32'h50);
        chained = 1'b0;
        // Immediate forms on mtvec keep values word aligned
        add_entry(itype_word(MTVEC_ADDR, 5'h0C, 3'b101, 5'd26, SYSTEM_OP), 1'b1, 5'd26,
                  32'h0, 1'b1, MTVEC_ADDR, 32'h0C, 1'b0, '0);
        chained = 1'b1;
        add_entry(itype_word(MTVEC_ADDR, 5'h10, 3'b110, 5'd27, SYSTEM_OP), 1'b1, 5'd27,
                  32'h0C, 1'b1, MTVEC_ADDR, 32'h1C, 1'b0, '0);
        add_entry(itype_word(MTVEC_ADDR, 5'h08, 3'b111, 5'd28, SYSTEM_OP), 1'b1, 5'd28,
                  32'h1C, 1'b1, MTVEC_ADDR, 32'h14, 1'b0, '0);
        chained = 1'b0;
        // mret returns to the mepc written two entries before
        add_entry(itype_word(MEPC_ADDR, 5'd9, 3'b001, 5'd0, SYSTEM_OP), 1'b0, '0,
                  '0, 1'b1, MEPC_ADDR, 32'h50, 1'b0, '0);
        chained = 1'b1;
        add_reg(itype_word(12'h001, 5'd0, 3'b000, 5'd29, I_TYPE_OP), 5'd29, 32'h1);
        add_branch(MRET_IR, 1'b1, 32'h50);
        chained = 1'b0;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_commit(input int k);
        if (k < 0) begin
            check_value("wb_valid", {31'b0, wb_valid}, 32'h0);
            check_value("csr_wb_valid", {31'b0, csr_wb_valid}, 32'h0);
            check_value("redirect_valid", {31'b0, redirect_valid}, 32'h0);
        end else begin
            check_value("wb_valid", {31'b0, wb_valid}, {31'b0, tab_wv[k]});
            if (tab_wv[k]) begin
                check_value("wb_rd", {27'b0, wb_rd}, {27'b0, tab_rd[k]});
                check_value("wb_data", wb_data, tab_data[k]);
            end
            check_value("csr_wb_valid", {31'b0, csr_wb_valid}, {31'b0, tab_cv[k]});
            if (tab_cv[k]) begin
                check_value("csr_wb_addr", {20'b0, csr_wb_addr}, {20'b0, tab_caddr[k]});
                check_value("csr_wb_data", csr_wb_data, tab_cdata[k]);
            end
            check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, tab_rv[k]});
            if (tab_rv[k]) begin
                check_value("redirect_pc", redirect_pc, tab_rpc[k]);
            end
        end
    endtask

    // Results of a slot appear two edges after it is sampled
    always @(negedge clk) begin
        if (arst_n) begin
            pending.push_back(drive_idx);
            if (pending.size() > 2) begin
                check_commit(pending.pop_front());
            end
        end
    end

    initial begin
        int gap;
        arst_n   = 1'b0;
        ir_valid = 1'b0;
        ir       = '0;
        pc       = '0;
        build_table();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < count; i++) begin
            gap = int'(next_rand() % 3);
            if (tab_chain[i]) begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                ir_valid  <= 1'b0;
                ir        <= '0;
                drive_idx <= -1;
            end
            @(posedge clk);
            ir        <= tab_ir[i];
            pc        <= tab_pc[i];
            ir_valid  <= 1'b1;
            drive_idx <= i;
        end
        @(posedge clk);
        ir_valid  <= 1'b0;
        drive_idx <= -1;
        repeat (4) @(posedge clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        #1;
        #((count * 4 + 24) * 100);
        $display("Timeout: the run did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/rv_isa_pkg.sv
hdl/rv_csr_pkg.sv
hdl/imm_extractor.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/exec_slice_top.sv
test/exec_slice_sva.sv
test/exec_slice_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = exec_slice_tb
FILELIST  = sim.f

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
